//--- source/fir_serial_macros.svh
`ifndef FIR_SERIAL_MACROS_SVH
`define FIR_SERIAL_MACROS_SVH

// filter geometry
`define FIR_TAPS      8
`define FIR_SAMPLE_W  16  // sfix16_En15
`define FIR_COEFF_W   16  // sfix16_En16
`define FIR_ACC_W     33  // sfix33_En31

//////////////////////////////////////////////////////////////////////
// symmetric coefficient set in tap order
//////////////////////////////////////////////////////////////////////

`define FIR_COEFF_0   16'hddbb
`define FIR_COEFF_1   16'hea8e
`define FIR_COEFF_2   16'h33db
`define FIR_COEFF_3   16'h6808
`define FIR_COEFF_4   16'h6808
`define FIR_COEFF_5   16'h33db
`define FIR_COEFF_6   16'hea8e
`define FIR_COEFF_7   16'hddbb

`endif

//--- source/fir_serial_pkg.sv
`include "fir_serial_macros.svh"

package fir_serial_pkg;

  // input sample
  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;

  // tap weight
  typedef logic signed [`FIR_COEFF_W-1:0] coeff_t;

  // full precision sample times weight
  typedef logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W-1:0] product_t;

  // running sum and filter output
  typedef logic signed [`FIR_ACC_W-1:0] acc_t;

  // selects one of the taps
  typedef logic [$clog2(`FIR_TAPS)-1:0] tap_idx_t;

endpackage

//--- source/carry_skip_adder.sv
module carry_skip_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  output logic [WIDTH-1:0] sum
);

  localparam int BLOCK = 4;  // bits per skip block

  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;

  assign p = x ^ y;
  assign g = x & y;

  // ripple inside a block, skip mux at each block boundary
  always_comb begin
    logic carry;
    logic blk_cin;
    logic blk_prop;
    carry    = 1'b0;
    blk_cin  = 1'b0;
    blk_prop = 1'b1;
    for (int i = 0; i < WIDTH; i++) begin
      if (i % BLOCK == 0) begin
        blk_cin  = carry;
        blk_prop = 1'b1;
      end
      sum[i]   = p[i] ^ carry;
      blk_prop = blk_prop & p[i];
      carry    = g[i] | (p[i] & carry);
      if (i % BLOCK == BLOCK - 1) begin
        carry = blk_prop ? blk_cin : carry;  // whole block propagates
      end
    end
  end

endmodule

//--- source/vedic_multiplier.sv
module vedic_multiplier #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  output logic [2*WIDTH-1:0] product
);

  generate
    if (WIDTH == 2) begin : g_base

      //////////////////////////////////////////////////////////////////////
      // 2x2 leaf from AND gates and two half adders
      //////////////////////////////////////////////////////////////////////

      logic [2:0] pp;
      logic       carry;

      assign pp[0] = a[1] & b[0];
      assign pp[1] = a[0] & b[1];
      assign pp[2] = a[1] & b[1];

      assign product[0] = a[0] & b[0];
      assign product[1] = pp[0] ^ pp[1];  // first half adder
      assign carry      = pp[0] & pp[1];
      assign product[2] = pp[2] ^ carry;  // second half adder
      assign product[3] = pp[2] & carry;

    end else begin : g_split

      //////////////////////////////////////////////////////////////////////
      // quarter the operands, then fold the four partial products
      //////////////////////////////////////////////////////////////////////

      localparam int H = WIDTH / 2;

      logic [WIDTH-1:0]   q0;  // lo x lo
      logic [WIDTH-1:0]   q1;  // hi x lo
      logic [WIDTH-1:0]   q2;  // lo x hi
      logic [WIDTH-1:0]   q3;  // hi x hi
      logic [WIDTH-1:0]   mid_lo;
      logic [WIDTH+H-1:0] mid_hi;
      logic [WIDTH+H-1:0] upper;

      vedic_multiplier #(.WIDTH(H)) u_mul_ll (
        .a       (a[H-1:0]),
        .b       (b[H-1:0]),
        .product (q0)
      );

      vedic_multiplier #(.WIDTH(H)) u_mul_hl (
        .a       (a[WIDTH-1:H]),
        .b       (b[H-1:0]),
        .product (q1)
      );

      vedic_multiplier #(.WIDTH(H)) u_mul_lh (
        .a       (a[H-1:0]),
        .b       (b[WIDTH-1:H]),
        .product (q2)
      );

      vedic_multiplier #(.WIDTH(H)) u_mul_hh (
        .a       (a[WIDTH-1:H]),
        .b       (b[WIDTH-1:H]),
        .product (q3)
      );

      // upper half of q0 plus one cross term
      carry_skip_adder #(.WIDTH(WIDTH)) u_add_lo (
        .x   ({{H{1'b0}}, q0[WIDTH-1:H]}),
        .y   (q1),
        .sum (mid_lo)
      );

      // other cross term plus shifted hi x hi
      carry_skip_adder #(.WIDTH(WIDTH+H)) u_add_hi (
        .x   ({{H{1'b0}}, q2}),
        .y   ({q3, {H{1'b0}}}),
        .sum (mid_hi)
      );

      carry_skip_adder #(.WIDTH(WIDTH+H)) u_add_all (
        .x   ({{H{1'b0}}, mid_lo}),
        .y   (mid_hi),
        .sum (upper)
      );

      assign product = {upper, q0[H-1:0]};  // low bits pass straight through

    end
  endgenerate

endmodule

//--- source/tap_counter.sv
module tap_counter import fir_serial_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     clk_enable,
  output tap_idx_t tap_idx,
  output logic     frame_start,
  output logic     frame_end
);

  localparam tap_idx_t FIRST_TAP = '0;
  localparam tap_idx_t LAST_TAP  = '1;

  // modulo-8 index, parked on the last tap out of reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tap_idx <= LAST_TAP;
    end else if (clk_enable) begin
      if (tap_idx == LAST_TAP) begin
        tap_idx <= FIRST_TAP;
      end else begin
        tap_idx <= tap_idx + 1'b1;
      end
    end
  end

  // phase strobes only count on enabled edges
  assign frame_start = clk_enable && (tap_idx == FIRST_TAP);
  assign frame_end   = clk_enable && (tap_idx == LAST_TAP);  // capture edge

endmodule

//--- source/sample_delay_line.sv
`include "fir_serial_macros.svh"

module sample_delay_line import fir_serial_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     shift_en,
  input  sample_t  filter_in,
  input  tap_idx_t tap_idx,
  output sample_t  tap_sample
);

  sample_t taps [`FIR_TAPS];  // entry 0 is the newest sample

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `FIR_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (shift_en) begin
      taps[0] <= filter_in;
      for (int i = 1; i < `FIR_TAPS; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // one tap per cycle into the multiplier
  assign tap_sample = taps[tap_idx];

endmodule

//--- source/serial_mac.sv
`include "fir_serial_macros.svh"

module serial_mac import fir_serial_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     clk_enable,
  input  logic     frame_start,
  input  logic     frame_end,
  input  sample_t  tap_sample,
  input  tap_idx_t tap_idx,
  output acc_t     filter_out
);

  coeff_t                    coeff;
  logic [`FIR_SAMPLE_W-1:0]  sample_mag;
  logic [`FIR_SAMPLE_W-1:0]  coeff_mag;
  logic [2*`FIR_SAMPLE_W-1:0] mag_product;
  logic                      negate;
  product_t                  product;
  acc_t                      product_ext;
  acc_t                      acc_sum;
  acc_t                      acc_reg;
  acc_t                      final_sum;

  always_comb begin
    case (tap_idx)
      3'd0:    coeff = `FIR_COEFF_0;
      3'd1:    coeff = `FIR_COEFF_1;
      3'd2:    coeff = `FIR_COEFF_2;
      3'd3:    coeff = `FIR_COEFF_3;
      3'd4:    coeff = `FIR_COEFF_4;
      3'd5:    coeff = `FIR_COEFF_5;
      3'd6:    coeff = `FIR_COEFF_6;
      default: coeff = `FIR_COEFF_7;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // sign-magnitude multiply
  //////////////////////////////////////////////////////////////////////

  assign sample_mag = tap_sample[`FIR_SAMPLE_W-1] ? -tap_sample : tap_sample;  // -32768 ok
  assign coeff_mag  = coeff[`FIR_COEFF_W-1] ? -coeff : coeff;
  assign negate     = tap_sample[`FIR_SAMPLE_W-1] ^ coeff[`FIR_COEFF_W-1];

  vedic_multiplier #(.WIDTH(`FIR_SAMPLE_W)) u_mul (
    .a       (sample_mag),
    .b       (coeff_mag),
    .product (mag_product)
  );

  assign product     = negate ? -product_t'(mag_product) : product_t'(mag_product);
  assign product_ext = acc_t'(product);  // sign extend to En31 acc

  carry_skip_adder #(.WIDTH(`FIR_ACC_W)) u_acc_add (
    .x   (product_ext),
    .y   (acc_reg),
    .sum (acc_sum)
  );

  //////////////////////////////////////////////////////////////////////
  // accumulate, final sum and output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_reg    <= '0;
      final_sum  <= '0;
      filter_out <= '0;
    end else begin
      if (clk_enable) begin
        acc_reg <= frame_start ? product_ext : acc_sum;  // tap 0 restarts the sum
      end
      if (frame_start) begin
        final_sum <= acc_reg;
      end
      if (frame_end) begin
        filter_out <= final_sum;
      end
    end
  end

endmodule

//--- source/fir_serial.sv
module fir_serial import fir_serial_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    clk_enable,
  input  sample_t filter_in,
  output acc_t    filter_out
);

  tap_idx_t tap_idx;
  logic     frame_start;
  logic     frame_end;
  sample_t  tap_sample;

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  tap_counter u_counter (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .tap_idx     (tap_idx),
    .frame_start (frame_start),
    .frame_end   (frame_end)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  sample_delay_line u_delay (
    .clk        (clk),
    .reset      (reset),
    .shift_en   (frame_end),  // new sample on the last tap
    .filter_in  (filter_in),
    .tap_idx    (tap_idx),
    .tap_sample (tap_sample)
  );

  serial_mac u_mac (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .tap_sample  (tap_sample),
    .tap_idx     (tap_idx),
    .filter_out  (filter_out)
  );

endmodule

//--- tb/fir_ref.svh
`ifndef FIR_REF_SVH
`define FIR_REF_SVH

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

localparam coeff_t COEFFS [`FIR_TAPS] = '{
  `FIR_COEFF_0,
  `FIR_COEFF_1,
  `FIR_COEFF_2,
  `FIR_COEFF_3,
  `FIR_COEFF_4,
  `FIR_COEFF_5,
  `FIR_COEFF_6,
  `FIR_COEFF_7
};

// y[m] from the driven history, zero before the first sample
function automatic acc_t fir_ref(input sample_t hist[$], input int m);
  longint sum;
  int     k;
  sum = 0;
  for (k = 0; k < `FIR_TAPS; k++) begin
    if (m - k >= 0 && m - k < hist.size()) begin
      sum += longint'(COEFFS[k]) * longint'(hist[m - k]);
    end
  end
  return acc_t'(sum);  // wraps to 33 bits
endfunction

// impulse of 16'h7fff gives each coefficient scaled by 32767
function automatic acc_t scaled_coeff(input int m);
  longint value;
  value = 0;
  if (m >= 0 && m < `FIR_TAPS) begin
    value = longint'(COEFFS[m]) * 32767;
  end
  return acc_t'(value);
endfunction

//////////////////////////////////////////////////////////////////////
// compare
//////////////////////////////////////////////////////////////////////

task automatic check_output(input string name, input acc_t got, input acc_t exp);
  if (got !== exp) begin
    $display("[FAIL] time %0t %s got %0d expected %0d", $time, name, got, exp);
    err_count++;
    report_failure();
  end
endtask

`endif

//--- tb/tb_fir_serial.sv
`include "fir_serial_macros.svh"

module tb_fir_serial import fir_serial_pkg::*; ();

  logic    clk;
  logic    reset;
  logic    clk_enable;
  sample_t filter_in;
  acc_t    filter_out;

  integer  seed = 32'hcfcb;
  int      err_count = 0;
  int      tb_tap = 7;       // own copy of the tap index
  int      cap_count = 0;    // captures since reset
  int      stall_left = 0;
  acc_t    prev_out = '0;
  bit      impulse_mode = 1'b0;
  sample_t samples [$];      // current run, by capture number

  `include "fir_ref.svh"

  fir_serial dut0 (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure();
    $display("Some tests failed");
    $fatal(1, "run stopped at time %0t", $time);
  endtask

  task automatic apply_reset();
    reset      = 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    stall_left = 0;
    repeat (5) begin
      @(posedge clk);
      #2;
    end
    reset = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input bit stall);
    @(posedge clk);
    #2;
    filter_in = (cap_count < samples.size()) ? samples[cap_count] : '0;
    if (stall && stall_left > 0) begin
      clk_enable = 1'b0;
      stall_left--;
    end else if (stall && ($random(seed) & 3) == 0) begin
      clk_enable = 1'b0;  // start of a stretch of 1 to 8 cycles
      stall_left = $random(seed) & 7;
    end else begin
      clk_enable = 1'b1;
    end
  endtask

  // runs until the last sample's result has reached filter_out
  task automatic run_phase(input bit stall);
    int cycles;
    int limit;
    cycles = 0;
    limit  = 64 * (samples.size() + 3);
    while (cap_count < samples.size() + 2) begin
      drive_cycle(stall);
      cycles++;
      if (cycles > limit) begin
        $display("timeout: only %0d of %0d captures seen", cap_count, samples.size() + 2);
        report_failure();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  initial begin : compare_outputs
    logic en;
    acc_t exp_out;
    forever begin
      @(posedge clk);
      en = clk_enable;
      #1;
      if (reset) begin
        check_output("filter_out", filter_out, '0);
        tb_tap    = 7;
        cap_count = 0;
        prev_out  = '0;
      end else if (en && tb_tap == 7) begin
        exp_out = fir_ref(samples, cap_count - 2);
        check_output("filter_out", filter_out, exp_out);
        if (impulse_mode) begin
          check_output("filter_out", filter_out, scaled_coeff(cap_count - 2));
        end
        prev_out = exp_out;
        cap_count++;
        tb_tap = 0;
      end else begin
        check_output("filter_out", filter_out, prev_out);  // holds through stalls
        if (en) begin
          tb_tap++;
        end
      end
    end
  end

  initial begin : main_sequence
    int i;
    // impulse covers the zero output after reset too
    impulse_mode = 1'b1;
    samples.push_back(16'sh7fff);
    for (i = 0; i < 9; i++) begin
      samples.push_back('0);
    end
    apply_reset();
    run_phase(1'b0);
    impulse_mode = 1'b0;

    samples.delete();  // full scale runs of both signs
    for (i = 0; i < 30; i++) begin
      samples.push_back((i < 10 || (i >= 20 && i % 2 == 0)) ? 16'sh8000 : 16'sh7fff);
    end
    apply_reset();
    run_phase(1'b0);

    samples.delete();
    for (i = 0; i < 200; i++) begin
      samples.push_back(sample_t'($random(seed)));
    end
    apply_reset();
    run_phase(1'b0);

    // same samples with stalls
    apply_reset();
    run_phase(1'b1);

    if (err_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

//--- fir_serial.f
+incdir+source
+incdir+tb
source/fir_serial_pkg.sv
source/carry_skip_adder.sv
source/vedic_multiplier.sv
source/tap_counter.sv
source/sample_delay_line.sv
source/serial_mac.sv
source/fir_serial.sv
tb/tb_fir_serial.sv

//--- Makefile
# Verilator flow for the serial FIR filter

VERILATOR  ?= verilator
TOP        := tb_fir_serial
RTL_TOP    := fir_serial
FILELIST   := fir_serial.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation of $(RTL_TOP) failed"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || \
		(echo "simulation of $(RTL_TOP) ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
